// File: source/regFilePkg.sv
// shared widths and types for the 16-bit four-port register file
// widths are fixed by the 4-bit slice, nothing here is meant to be overridden

package regFilePkg;

    // slice geometry
    localparam int SliceWidth = 4;                      // bits held by one slice
    localparam int NumSlices  = 4;                      // slices chained per word
    localparam int WordWidth  = SliceWidth * NumSlices; // full data width, 16

    // register array
    localparam int NumRegs    = 4;                      // RG0..RG3
    localparam int NumPorts   = 4;                      // A, B, C, X

    // one slice's share of a word
    typedef logic [SliceWidth-1:0] nibble;

    // full register value as seen at the ports
    typedef logic [WordWidth-1:0] dataWord;

    // register number on a port
    typedef logic [$clog2(NumRegs)-1:0] regAddr;

    // one-hot register select, bit r targets RGr
    typedef logic [NumRegs-1:0] regSelect;

endpackage : regFilePkg

// File: source/portDecoder.sv
// command decode, pure combinational, no state
// inputs only count in a cycle with cmdStrobe high
// a write to RG0 from any port suppresses the count
module portDecoder import regFilePkg::*; (
    input  logic     cmdStrobe,     // one-cycle command strobe
    input  logic     incr,          // count request for RG0

    input  logic     aEn,           // port A enable
    input  logic     aWr,           // port A write request
    input  logic     aRd,           // port A read request
    input  regAddr   aAddr,         // port A register
    input  dataWord  aWrData,       // port A write data

    input  logic     bEn,
    input  logic     bWr,
    input  logic     bRd,
    input  regAddr   bAddr,
    input  dataWord  bWrData,

    input  logic     cEn,
    input  logic     cWr,
    input  logic     cRd,
    input  regAddr   cAddr,
    input  dataWord  cWrData,

    input  logic     xEn,
    input  logic     xWr,
    input  logic     xRd,
    input  regAddr   xAddr,
    input  dataWord  xWrData,

    output logic     cmdValid,      // strobe forwarded to the combiner

    output regSelect aWrSel,        // one-hot write target, zero if no write
    output regAddr   aAddrQ,        // address for the read mux
    output dataWord  aWrWord,       // write data, unchanged
    output logic     aRdEn,         // read enable, gated

    output regSelect bWrSel,
    output regAddr   bAddrQ,
    output dataWord  bWrWord,
    output logic     bRdEn,

    output regSelect cWrSel,
    output regAddr   cAddrQ,
    output dataWord  cWrWord,
    output logic     cRdEn,

    output regSelect xWrSel,
    output regAddr   xAddrQ,
    output dataWord  xWrWord,
    output logic     xRdEn,

    output logic     cntEn          // RG0 count, after write priority
);

    logic [NumPorts-1:0] wrReq;     // per-port write request, bit 0 is A
    logic [NumPorts-1:0] rg0Hit;    // per-port write aimed at RG0

    // one-hot select for a port, all zero when the port does not write
    function automatic regSelect selFor(input logic req, input regAddr addr);
        regSelect sel;
        sel = '0;
        if (req) begin
            sel[addr] = 1'b1;
        end
        return sel;
    endfunction

    // write requests need strobe, enable and write
    assign wrReq[0] = cmdStrobe & aEn & aWr;
    assign wrReq[1] = cmdStrobe & bEn & bWr;
    assign wrReq[2] = cmdStrobe & cEn & cWr;
    assign wrReq[3] = cmdStrobe & xEn & xWr;

    assign aWrSel = selFor(wrReq[0], aAddr);
    assign bWrSel = selFor(wrReq[1], bAddr);
    assign cWrSel = selFor(wrReq[2], cAddr);
    assign xWrSel = selFor(wrReq[3], xAddr);

    // address and data go through as they are
    assign aAddrQ  = aAddr;
    assign bAddrQ  = bAddr;
    assign cAddrQ  = cAddr;
    assign xAddrQ  = xAddr;
    assign aWrWord = aWrData;
    assign bWrWord = bWrData;
    assign cWrWord = cWrData;
    assign xWrWord = xWrData;

    // read enables, the combiner masks with these
    assign aRdEn = cmdStrobe & aEn & aRd;
    assign bRdEn = cmdStrobe & bEn & bRd;
    assign cRdEn = cmdStrobe & cEn & cRd;
    assign xRdEn = cmdStrobe & xEn & xRd;

    // any port writing RG0 beats the count
    assign rg0Hit = {xWrSel[0], cWrSel[0], bWrSel[0], aWrSel[0]};
    assign cntEn  = cmdStrobe & incr & ~(|rg0Hit);

    assign cmdValid = cmdStrobe;

endmodule : portDecoder

// File: source/regSlice.sv
// one 4-bit slice, four registers, RG0 counts on carryIn
// same-register writes from several ports merge by OR
// read nibbles and carryOut come straight from the stored state
module regSlice import regFilePkg::*; (
    input  logic     clk0,
    input  logic     arstN,

    input  regSelect aWrSel,        // write targets per port
    input  regSelect bWrSel,
    input  regSelect cWrSel,
    input  regSelect xWrSel,

    input  regAddr   aAddrQ,        // read addresses per port
    input  regAddr   bAddrQ,
    input  regAddr   cAddrQ,
    input  regAddr   xAddrQ,

    input  nibble    aWrNib,        // this slice's share of the write words
    input  nibble    bWrNib,
    input  nibble    cWrNib,
    input  nibble    xWrNib,

    input  logic     carryIn,       // count into RG0, from slice below

    output nibble    aRdNib,        // unmasked read data per port
    output nibble    bRdNib,
    output nibble    cRdNib,
    output nibble    xRdNib,

    output logic     carryOut,      // carry to slice above
    output logic     sliceEqual     // RG0 == RG3 in this slice
);

    nibble    rg [NumRegs];         // RG0..RG3
    nibble    mergeData [NumRegs];  // OR of all data aimed at each reg
    regSelect wrHit;                // reg written by at least one port

    // wired-OR merge, like the bus on the real part
    always_comb begin
        for (int r = 0; r < NumRegs; r++) begin
            wrHit[r]     = aWrSel[r] | bWrSel[r] | cWrSel[r] | xWrSel[r];
            mergeData[r] = (aWrSel[r] ? aWrNib : '0) |
                           (bWrSel[r] ? bWrNib : '0) |
                           (cWrSel[r] ? cWrNib : '0) |
                           (xWrSel[r] ? xWrNib : '0);
        end
    end

    always_ff @(posedge clk0 or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < NumRegs; r++) begin
                rg[r] <= '0;
            end
        end else begin
            for (int r = 0; r < NumRegs; r++) begin
                if (wrHit[r]) begin
                    rg[r] <= mergeData[r];      // write wins
                end else if (r == 0 && carryIn) begin
                    rg[r] <= rg[r] + 1'b1;      // count, wraps at 4'hF
                end
            end
        end
    end

    // read muxes, old value during a write
    assign aRdNib = rg[aAddrQ];
    assign bRdNib = rg[bAddrQ];
    assign cRdNib = rg[cAddrQ];
    assign xRdNib = rg[xAddrQ];

    // ripple carry, passes only when RG0 is all ones
    assign carryOut   = carryIn & (&rg[0]);
    assign sliceEqual = (rg[0] == rg[NumRegs-1]);

endmodule : regSlice

// File: source/readCombiner.sv
// output stage, one cycle after the command
// ports not read give zero, all outputs are zero in cycles without rdValid
module readCombiner import regFilePkg::*; (
    input  logic                 clk0,
    input  logic                 arstN,

    input  logic                 cmdValid,   // command this cycle

    input  logic                 aRdEn,      // read enables per port
    input  logic                 bRdEn,
    input  logic                 cRdEn,
    input  logic                 xRdEn,

    input  dataWord              aNibs,      // slice nibbles, slice 0 in bits 3:0
    input  dataWord              bNibs,
    input  dataWord              cNibs,
    input  dataWord              xNibs,

    input  logic [NumSlices-1:0] sliceEqual, // per-slice RG0 == RG3
    input  logic                 lastCarry,  // carry out of top slice

    output logic                 rdValid,    // one pulse per command
    output dataWord              aRdData,
    output dataWord              bRdData,
    output dataWord              cRdData,
    output dataWord              xRdData,
    output logic                 equal,      // whole-word RG0 == RG3
    output logic                 overflow    // counter wrapped from all ones
);

    dataWord aMasked;
    dataWord bMasked;
    dataWord cMasked;
    dataWord xMasked;
    logic    wordEqual;

    // unread ports drive zero
    assign aMasked = aRdEn ? aNibs : '0;
    assign bMasked = bRdEn ? bNibs : '0;
    assign cMasked = cRdEn ? cNibs : '0;
    assign xMasked = xRdEn ? xNibs : '0;

    assign wordEqual = &sliceEqual; // every nibble must match

    always_ff @(posedge clk0 or negedge arstN) begin
        if (!arstN) begin
            rdValid  <= 1'b0;
            aRdData  <= '0;
            bRdData  <= '0;
            cRdData  <= '0;
            xRdData  <= '0;
            equal    <= 1'b0;   // low after reset even with RG0 == RG3
            overflow <= 1'b0;
        end else begin
            rdValid <= cmdValid;
            if (cmdValid) begin
                aRdData  <= aMasked;
                bRdData  <= bMasked;
                cRdData  <= cMasked;
                xRdData  <= xMasked;
                equal    <= wordEqual;
                overflow <= lastCarry;  // cntEn already folded in
            end else begin
                aRdData  <= '0;         // idle cycle
                bRdData  <= '0;
                cRdData  <= '0;
                xRdData  <= '0;
                equal    <= 1'b0;
                overflow <= 1'b0;
            end
        end
    end

endmodule : readCombiner

// File: source/multiportRegFile.sv
// 16-bit four-port register file built from four 4-bit slices
// writes commit at the edge after cmdStrobe, results show one cycle later
// back-to-back strobes allowed, there is no back-pressure
module multiportRegFile import regFilePkg::*; (
    input  logic    clk0,
    input  logic    arstN,
    input  logic    cmdStrobe,      // one-cycle command strobe
    input  logic    incr,           // count RG0

    input  logic    aEn,
    input  logic    aWr,
    input  logic    aRd,
    input  regAddr  aAddr,
    input  dataWord aWrData,

    input  logic    bEn,
    input  logic    bWr,
    input  logic    bRd,
    input  regAddr  bAddr,
    input  dataWord bWrData,

    input  logic    cEn,
    input  logic    cWr,
    input  logic    cRd,
    input  regAddr  cAddr,
    input  dataWord cWrData,

    input  logic    xEn,
    input  logic    xWr,
    input  logic    xRd,
    input  regAddr  xAddr,
    input  dataWord xWrData,

    output logic    rdValid,
    output dataWord aRdData,
    output dataWord bRdData,
    output dataWord cRdData,
    output dataWord xRdData,
    output logic    equal,
    output logic    overflow
);

    logic                 cmdValid;
    regSelect             aWrSel, bWrSel, cWrSel, xWrSel;
    regAddr               aAddrQ, bAddrQ, cAddrQ, xAddrQ;
    dataWord              aWrWord, bWrWord, cWrWord, xWrWord;
    logic                 aRdEn, bRdEn, cRdEn, xRdEn;
    logic                 cntEn;

    logic [NumSlices:0]   carry;        // carry[0] in, carry[NumSlices] overflow
    logic [NumSlices-1:0] sliceEqual;
    dataWord              aNibs, bNibs, cNibs, xNibs;   // reassembled read words

    portDecoder decoder_i (
        .cmdStrobe, .incr,
        .aEn, .aWr, .aRd, .aAddr, .aWrData,
        .bEn, .bWr, .bRd, .bAddr, .bWrData,
        .cEn, .cWr, .cRd, .cAddr, .cWrData,
        .xEn, .xWr, .xRd, .xAddr, .xWrData,
        .cmdValid,
        .aWrSel, .aAddrQ, .aWrWord, .aRdEn,
        .bWrSel, .bAddrQ, .bWrWord, .bRdEn,
        .cWrSel, .cAddrQ, .cWrWord, .cRdEn,
        .xWrSel, .xAddrQ, .xWrWord, .xRdEn,
        .cntEn
    );

    assign carry[0] = cntEn;    // count enters at the low slice

    for (genvar sl = 0; sl < NumSlices; sl++) begin : sliceGen
        regSlice slice_i (
            .clk0, .arstN,
            .aWrSel, .bWrSel, .cWrSel, .xWrSel,
            .aAddrQ, .bAddrQ, .cAddrQ, .xAddrQ,
            .aWrNib     (aWrWord[sl*SliceWidth +: SliceWidth]),
            .bWrNib     (bWrWord[sl*SliceWidth +: SliceWidth]),
            .cWrNib     (cWrWord[sl*SliceWidth +: SliceWidth]),
            .xWrNib     (xWrWord[sl*SliceWidth +: SliceWidth]),
            .carryIn    (carry[sl]),
            .aRdNib     (aNibs[sl*SliceWidth +: SliceWidth]),
            .bRdNib     (bNibs[sl*SliceWidth +: SliceWidth]),
            .cRdNib     (cNibs[sl*SliceWidth +: SliceWidth]),
            .xRdNib     (xNibs[sl*SliceWidth +: SliceWidth]),
            .carryOut   (carry[sl+1]),
            .sliceEqual (sliceEqual[sl])
        );
    end : sliceGen

    readCombiner combiner_i (
        .clk0, .arstN,
        .cmdValid,
        .aRdEn, .bRdEn, .cRdEn, .xRdEn,
        .aNibs, .bNibs, .cNibs, .xNibs,
        .sliceEqual,
        .lastCarry  (carry[NumSlices]),
        .rdValid,
        .aRdData, .bRdData, .cRdData, .xRdData,
        .equal, .overflow
    );

endmodule : multiportRegFile

// File: tests/tbClockGen.sv
// testbench clock and reset, period 4 time units
// arstN is held low for 16 cycles and released on a falling edge
module tbClockGen (
    output logic clk0,
    output logic arstN
);

    initial begin
        clk0 = 1'b0;
        forever #2 clk0 = ~clk0;    // period 4
    end

    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge clk0);
        @(negedge clk0);            // release away from the active edge
        arstN = 1'b1;
    end

endmodule : tbClockGen

// File: tests/tbMultiportRegFile.sv
// table-driven testbench for the four-port register file
// directed rows carry their own expected values, random rows take them from a register model
// every result is due exactly one cycle after its strobe
module tbMultiportRegFile import regFilePkg::*; ();

    localparam int NumDirected   = 19;
    localparam int NumRows       = 40;
    localparam int TimeoutCycles = 16 + 4 * NumRows + 20;

    logic    clk0, arstN, cmdStrobe, incr;
    logic    aEn, bEn, cEn, xEn;
    logic    aWr, bWr, cWr, xWr;
    logic    aRd, bRd, cRd, xRd;
    regAddr  aAddr, bAddr, cAddr, xAddr;
    dataWord aWrData, bWrData, cWrData, xWrData;
    logic    rdValid, equal, overflow;
    dataWord aRdData, bRdData, cRdData, xRdData;

    // command table where bit p of the port vectors is port A, B, C, X
    logic [3:0]  rowEn   [NumRows];
    logic [3:0]  rowWr   [NumRows];
    logic [3:0]  rowRd   [NumRows];
    logic [7:0]  rowAddr [NumRows];         // two bits per port with A in 1:0
    dataWord     rowData [NumRows][NumPorts];
    logic        rowIncr [NumRows];
    logic        rowB2b  [NumRows];         // no idle cycle before this row
    logic        rowRand [NumRows];
    dataWord     expRd   [NumRows][NumPorts];
    logic        expEq   [NumRows];
    logic        expOvf  [NumRows];

    dataWord     modelRegs [NumRegs];       // RG0..RG3 as the model sees them
    logic [31:0] rngState;
    int          rowCount;
    int          errorCount;
    int          checkCount;
    int          cycleCount;

    tbClockGen clkGen_i (.clk0, .arstN);

    multiportRegFile dut_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic checkWord(input string name, input dataWord got, input dataWord exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // outputs when no result is pending
    task automatic checkNoResult();
        checkFlag("rdValid", rdValid, 1'b0);
        checkFlag("overflow", overflow, 1'b0);
        checkWord("aRdData", aRdData, '0);
        checkWord("bRdData", bRdData, '0);
        checkWord("cRdData", cRdData, '0);
        checkWord("xRdData", xRdData, '0);
    endtask

    task automatic addRow(input logic b2b, input logic inc, input logic [3:0] en, wr, rd,
                          input logic [7:0] addr, input dataWord dA, dB, dC, dX,
                          input dataWord eA, eB, eC, eX, input logic eq, ovf);
        rowB2b[rowCount]     = b2b;
        rowIncr[rowCount]    = inc;
        rowEn[rowCount]      = en;
        rowWr[rowCount]      = wr;
        rowRd[rowCount]      = rd;
        rowAddr[rowCount]    = addr;
        rowData[rowCount][0] = dA;
        rowData[rowCount][1] = dB;
        rowData[rowCount][2] = dC;
        rowData[rowCount][3] = dX;
        expRd[rowCount][0]   = eA;
        expRd[rowCount][1]   = eB;
        expRd[rowCount][2]   = eC;
        expRd[rowCount][3]   = eX;
        expEq[rowCount]      = eq;
        expOvf[rowCount]     = ovf;
        rowRand[rowCount]    = 1'b0;
        rowCount++;
    endtask

    // one command through the model with reads and flags from the old state
    task automatic runModel(input int r);
        logic    rg0Write;
        logic    countEn;
        logic    hit;
        dataWord merged;
        rg0Write = 1'b0;
        for (int p = 0; p < NumPorts; p++) begin
            if (rowEn[r][p] && rowWr[r][p] && rowAddr[r][2*p +: 2] == 2'd0) begin
                rg0Write = 1'b1;                    // write beats count
            end
        end
        countEn = rowIncr[r] && !rg0Write;
        if (rowRand[r]) begin
            for (int p = 0; p < NumPorts; p++) begin
                expRd[r][p] = (rowEn[r][p] && rowRd[r][p]) ?
                              modelRegs[rowAddr[r][2*p +: 2]] : '0;
            end
            expEq[r]  = (modelRegs[0] == modelRegs[NumRegs-1]);
            expOvf[r] = countEn && (modelRegs[0] == 16'hFFFF);
        end
        for (int q = 0; q < NumRegs; q++) begin
            hit    = 1'b0;
            merged = '0;
            for (int p = 0; p < NumPorts; p++) begin
                if (rowEn[r][p] && rowWr[r][p] && rowAddr[r][2*p +: 2] == q) begin
                    hit    = 1'b1;
                    merged = merged | rowData[r][p];    // wired OR
                end
            end
            if (hit) begin
                modelRegs[q] = merged;
            end else if (q == 0 && countEn) begin
                modelRegs[0] = modelRegs[0] + 1'b1;     // wraps at FFFF
            end
        end
    endtask

    task automatic buildTable();
        rowCount = 0;
        // write RG0..RG3 from A..X, then read them back, then masked reads
        addRow(0, 0, 4'hF, 4'hF, 4'h0, 8'hE4, 16'h1111, 16'h2222, 16'h3333, 16'h4444,
               16'h0, 16'h0, 16'h0, 16'h0, 1, 0);
        addRow(0, 0, 4'hF, 4'h0, 4'hF, 8'hE4, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h1111, 16'h2222, 16'h3333, 16'h4444, 0, 0);
        addRow(0, 0, 4'hD, 4'h0, 4'h7, 8'h93, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h4444, 16'h0, 16'h2222, 16'h0, 0, 0);
        // read during write gives the old value
        addRow(0, 0, 4'h1, 4'h1, 4'h1, 8'h01, 16'hABCD, 16'h0, 16'h0, 16'h0,
               16'h2222, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(1, 0, 4'h2, 4'h0, 4'h2, 8'h04, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h0, 16'hABCD, 16'h0, 16'h0, 0, 0);
        // A and C both write RG2 while X reads it
        addRow(0, 0, 4'hD, 4'h5, 4'h8, 8'hA2, 16'h00F0, 16'h0, 16'h0F01, 16'h0,
               16'h0, 16'h0, 16'h0, 16'h3333, 0, 0);
        addRow(0, 0, 4'h1, 4'h0, 4'h1, 8'h02, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h0FF1, 16'h0, 16'h0, 16'h0, 0, 0);
        // counter carry across the low slices
        addRow(0, 0, 4'h3, 4'h3, 4'h0, 8'h0C, 16'h00FE, 16'h0100, 16'h0, 16'h0,
               16'h0, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(0, 1, 4'h1, 4'h0, 4'h1, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h00FE, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(1, 1, 4'h1, 4'h0, 4'h1, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h00FF, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(0, 0, 4'h3, 4'h0, 4'h3, 8'h0C, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h0100, 16'h0100, 16'h0, 16'h0, 1, 0);
        // wrap from FFFF
        addRow(0, 0, 4'h8, 4'h8, 4'h0, 8'h00, 16'h0, 16'h0, 16'h0, 16'hFFFF,
               16'h0, 16'h0, 16'h0, 16'h0, 1, 0);
        addRow(0, 1, 4'h4, 4'h0, 4'h4, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h0, 16'h0, 16'hFFFF, 16'h0, 0, 1);
        // write to RG0 wins over incr
        addRow(0, 1, 4'h3, 4'h2, 4'h1, 8'h00, 16'h0, 16'h1234, 16'h0, 16'h0,
               16'h0, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(1, 1, 4'h1, 4'h0, 4'h1, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h1234, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(0, 0, 4'h1, 4'h0, 4'h1, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h1235, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(0, 0, 4'h8, 4'h8, 4'h0, 8'h00, 16'h0, 16'h0, 16'h0, 16'hFFFF,
               16'h0, 16'h0, 16'h0, 16'h0, 0, 0);
        addRow(0, 1, 4'h3, 4'h1, 4'h2, 8'h00, 16'h0007, 16'h0, 16'h0, 16'h0,
               16'h0, 16'hFFFF, 16'h0, 16'h0, 0, 0);    // no overflow since the count is lost
        addRow(0, 0, 4'h1, 4'h0, 4'h1, 8'h00, 16'h0, 16'h0, 16'h0, 16'h0,
               16'h0007, 16'h0, 16'h0, 16'h0, 0, 0);
        rngState = 32'h8f89;
        for (int r = NumDirected; r < NumRows; r++) begin
            rngState   = xorshift32(rngState);
            rowEn[r]   = rngState[3:0];
            rowWr[r]   = rngState[7:4];
            rowRd[r]   = rngState[11:8];
            rowAddr[r] = rngState[19:12];
            rowIncr[r] = rngState[20] | rngState[21];   // count most of the time
            rowB2b[r]  = rngState[22];
            rowRand[r] = 1'b1;
            for (int p = 0; p < NumPorts; p++) begin
                rngState      = xorshift32(rngState);
                rowData[r][p] = rngState[31] ? 16'hFFFF : rngState[15:0];
            end
        end
    endtask

    task automatic driveRow(input int r);
        cmdStrobe <= 1'b1;
        incr      <= rowIncr[r];
        {xEn, cEn, bEn, aEn}         <= rowEn[r];
        {xWr, cWr, bWr, aWr}         <= rowWr[r];
        {xRd, cRd, bRd, aRd}         <= rowRd[r];
        {xAddr, cAddr, bAddr, aAddr} <= rowAddr[r];
        aWrData <= rowData[r][0];
        bWrData <= rowData[r][1];
        cWrData <= rowData[r][2];
        xWrData <= rowData[r][3];
    endtask

    task automatic checkRow(input int r);
        int errorsAtStart;
        errorsAtStart = errorCount;
        checkWord("aRdData", aRdData, expRd[r][0]);
        checkWord("bRdData", bRdData, expRd[r][1]);
        checkWord("cRdData", cRdData, expRd[r][2]);
        checkWord("xRdData", xRdData, expRd[r][3]);
        checkFlag("equal", equal, expEq[r]);
        checkFlag("overflow", overflow, expOvf[r]);
        $display("row %0d (%s) done, %0d mismatches", r,
                 rowRand[r] ? "random" : "directed", errorCount - errorsAtStart);
    endtask

    initial begin
        int r;
        int curRow;
        int prevRow;
        {cmdStrobe, incr} = 2'b00;
        {aEn, bEn, cEn, xEn} = 4'h0;
        {aWr, bWr, cWr, xWr} = 4'h0;
        {aRd, bRd, cRd, xRd} = 4'h0;
        {aAddr, bAddr, cAddr, xAddr} = 8'h00;
        {aWrData, bWrData, cWrData, xWrData} = '0;
        errorCount = 0;
        checkCount = 0;
        for (int q = 0; q < NumRegs; q++) begin
            modelRegs[q] = '0;
        end
        buildTable();
        for (r = 0; r < NumRows; r++) begin
            runModel(r);                    // expected values in command order
        end
        wait (arstN === 1'b1);
        @(negedge clk0);
        checkNoResult();
        checkFlag("equal", equal, 1'b0);    // low after reset though RG0 == RG3
        $display("reset state done, %0d mismatches", errorCount);
        r = 0;
        prevRow = -1;
        while (r < NumRows || prevRow >= 0) begin
            @(posedge clk0);
            curRow = -1;
            if (r < NumRows && (rowB2b[r] || prevRow < 0)) begin
                driveRow(r);
                curRow = r;
                r++;
            end else begin
                cmdStrobe <= 1'b0;          // idle cycle
                incr      <= 1'b0;
            end
            @(negedge clk0);
            if (prevRow >= 0 && rdValid === 1'b1) begin
                checkRow(prevRow);
            end else if (prevRow >= 0) begin
                errorCount++;
                $display("row %0d: rdValid did not come one cycle after the strobe", prevRow);
            end else begin
                checkNoResult();            // no command in flight
            end
            prevRow = curRow;
        end
        $display("rows %0d, checks %0d, errors %0d", NumRows, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // hard stop if the run hangs
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk0);
            cycleCount++;
        end
        $display("timeout, run still going after %0d cycles", TimeoutCycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule : tbMultiportRegFile

// File: files.f
source/regFilePkg.sv
source/portDecoder.sv
source/regSlice.sv
source/readCombiner.sv
source/multiportRegFile.sv
tests/tbClockGen.sv
tests/tbMultiportRegFile.sv
